/* files.f */
source/layer_pkg.sv
source/tile_addr_gen.sv
source/fetch_sequencer.sv
source/pixel_serializer.sv
source/layer_renderer.sv
testbench/vram_model.sv
testbench/layer_renderer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the tile layer renderer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module layer_renderer_tb \
    -f files.f -o layer_sim
./obj_dir/layer_sim 2>&1 | tee sim.log

grep -q "Simulation finished: PASS" sim.log

/* testbench/layer_renderer_tb.sv */
// Testbench for the tile layer line renderer: table-driven lines checked against a pixel model
`timescale 1ns/10ps

module layer_renderer_tb import layer_pkg::*; ();

    localparam int NUM_ROWS     = 6;
    localparam int LINE_TIMEOUT = 20000;
    localparam int QUIET_CYCLES = 8;

    // One line to render and what it must produce
    typedef struct packed {
        layer_cfg_t  cfg;
        line_idx_t   line;
        logic [10:0] writes;     // lb_wren pulses, fine scroll lead-in included
        lb_idx_t     abort_at;   // index where the next start cuts in, 0 runs to the end
    } stim_t;

    logic       clk;
    logic       rst;
    line_idx_t  line_idx;
    logic       line_render_start;
    layer_cfg_t cfg;
    vram_addr_t bus_addr;
    logic       bus_strobe;
    vram_word_t bus_rddata;
    logic       bus_ack;
    lb_idx_t    lb_wridx;
    color_t     lb_wrdata;
    logic       lb_wren;

    stim_t      stim [NUM_ROWS];
    int         mismatches;
    int         failures;
    int         pixels;
    logic       strobe_seen;
    vram_addr_t held_addr;

    layer_renderer layer_renderer_inst (
        .clk               (clk),
        .rst               (rst),
        .line_idx          (line_idx),
        .line_render_start (line_render_start),
        .cfg               (cfg),
        .bus_addr          (bus_addr),
        .bus_strobe        (bus_strobe),
        .bus_rddata        (bus_rddata),
        .bus_ack           (bus_ack),
        .lb_wridx          (lb_wridx),
        .lb_wrdata         (lb_wrdata),
        .lb_wren           (lb_wren)
    );

    vram_model vram_model_inst (
        .clk        (clk),
        .rst        (rst),
        .bus_addr   (bus_addr),
        .bus_strobe (bus_strobe),
        .bus_rddata (bus_rddata),
        .bus_ack    (bus_ack)
    );

    always #2 clk = ~clk;

    // Address must hold for the whole pending request
    always @(negedge clk) begin
        if (!rst) begin
            if (strobe_seen && bus_strobe) begin
                assert (bus_addr == held_addr) else begin
                    mismatches++;
                    $display("FAIL bus_addr: expected %h got %h", held_addr, bus_addr);
                end
            end
            strobe_seen = bus_strobe;
            held_addr   = bus_addr;
        end
    end

    function automatic stim_t make_row(input logic [1:0] depth, map_w, map_h,
                                       input logic [7:0] map_base, tile_base,
                                       input scroll_t hscroll, vscroll, input line_idx_t line,
                                       input logic [10:0] writes, input lb_idx_t abort_at);
        stim_t s;
        s.cfg.color_depth = depth;
        s.cfg.map_width   = map_w;
        s.cfg.map_height  = map_h;
        s.cfg.map_base    = map_base;
        s.cfg.tile_base   = tile_base;
        s.cfg.hscroll     = hscroll;
        s.cfg.vscroll     = vscroll;
        s.line            = line;
        s.writes          = writes;
        s.abort_at        = abort_at;
        return s;
    endfunction

    function automatic vram_word_t vram_word(input int addr);
        return vram_model_inst.mem[vram_addr_t'(addr)];
    endfunction

    ////////////////////
    // Reference pixel
    ////////////////////

    function automatic color_t expected_pixel(input layer_cfg_t c, input line_idx_t line,
                                              input int x);
        int          sl;
        int          fine;
        int          t;
        int          p;
        int          q;
        int          map_w;
        int          map_idx;
        int          tile;
        int          trow;
        int          waddr;
        int          shift;
        logic [15:0] entry;
        vram_word_t  w;
        logic        hf;
        logic        vf;
        logic [7:0]  attr;
        color_t      raw;

        sl    = (int'(line) + int'(c.vscroll)) % 4096;
        fine  = int'(c.hscroll) % 8;
        t     = (x + fine) / 8;
        p     = (x + fine) % 8;
        map_w = 32 << c.map_width;

        // Row and column wrap to the map size
        map_idx = ((sl / 8) % (32 << c.map_height)) * map_w
                + (t + int'(c.hscroll) / 8) % map_w;
        w     = vram_word(int'(c.map_base) * 128 + map_idx / 2);
        entry = (map_idx % 2 == 1) ? w[31:16] : w[15:0];

        if (c.color_depth == 2'd0) begin
            tile = int'(entry[7:0]);
            attr = entry[15:8];
            hf   = 1'b0;
            vf   = 1'b0;
        end else begin
            tile = int'(entry[9:0]);
            attr = {entry[15:12], 4'h0};
            hf   = entry[10];
            vf   = entry[11];
        end

        trow = vf ? 7 - sl % 8 : sl % 8;
        q    = hf ? 7 - p : p;

        // Word within the tile, then bit position of the pixel in it
        case (c.color_depth)
            2'd0: begin
                waddr = tile * 2 + trow / 4;
                shift = (trow % 4) * 8 + 7 - p;
            end
            2'd1: begin
                waddr = tile * 4 + trow / 2;
                shift = (trow % 2) * 16 + (q / 4) * 8 + (3 - q % 4) * 2;
            end
            2'd2: begin
                waddr = tile * 8 + trow;
                shift = (q / 2) * 8 + (1 - q % 2) * 4;
            end
            default: begin
                waddr = tile * 16 + trow * 2 + q / 4;
                shift = (q % 4) * 8;
            end
        endcase

        w = vram_word(int'(c.tile_base) * 128 + waddr) >> shift;

        if (c.color_depth == 2'd0) begin
            raw = w[0] ? {4'h0, attr[3:0]} : {4'h0, attr[7:4]};
        end else begin
            raw = w[7:0] & color_t'((1 << (1 << c.color_depth)) - 1);
            if (raw[7:4] == 4'h0 && raw[3:0] != 4'h0) begin
                raw[7:4] = attr[7:4];
            end
        end
        return raw;
    endfunction

    ////////////////////
    // Checkers
    ////////////////////

    task automatic check_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            assert (!bus_strobe && !lb_wren) else begin
                failures++;
                $display("Bus strobe or line buffer write seen before any start");
            end
        end
    endtask

    task automatic watch_quiet(input int r);
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            assert (!lb_wren) else begin
                failures++;
                $display("Line buffer written after the last column on table row %0d", r);
            end
        end
    endtask

    task automatic render_line(input int r);
        int     next_idx;
        int     writes;
        int     cycles;
        int     idx;
        logic   done;
        color_t exp;

        cfg               = stim[r].cfg;
        line_idx          = stim[r].line;
        line_render_start = 1'b1;
        @(negedge clk);
        line_render_start = 1'b0;

        next_idx = 0;
        writes   = 0;
        cycles   = 0;
        done     = 1'b0;
        while (!done && cycles < LINE_TIMEOUT) begin
            if (lb_wren) begin
                writes++;
                idx = int'(lb_wridx);
                // Lead-in writes left of column zero are dropped by the line buffer
                if (idx < LINE_PIXELS) begin
                    assert (idx == next_idx) else begin
                        mismatches++;
                        $display("FAIL lb_wridx: expected %h got %h", next_idx, lb_wridx);
                    end
                    exp = expected_pixel(stim[r].cfg, stim[r].line, idx);
                    assert (lb_wrdata == exp) else begin
                        mismatches++;
                        $display("FAIL lb_wrdata index %h: expected %h got %h",
                                 lb_wridx, exp, lb_wrdata);
                    end
                    pixels++;
                    next_idx = idx + 1;
                    done     = (idx == LINE_PIXELS - 1) ||
                               (stim[r].abort_at != '0 && lb_wridx == stim[r].abort_at);
                end
            end
            if (!done) begin
                @(negedge clk);
                cycles++;
            end
        end

        if (!done) begin
            failures++;
            $display("Timeout on table row %0d: line never reached its last column", r);
        end else if (stim[r].abort_at == '0) begin
            assert (writes == int'(stim[r].writes)) else begin
                mismatches++;
                $display("FAIL lb_wren count: expected %h got %h", stim[r].writes, writes);
            end
            watch_quiet(r);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        line_idx          = '0;
        line_render_start = 1'b0;
        cfg               = '0;
        mismatches        = 0;
        failures          = 0;
        pixels            = 0;
        strobe_seen       = 1'b0;
        held_addr         = '0;

        //                 bpp   w     h     map    tile   hscroll   vscroll   line
        stim[0] = make_row(2'd3, 2'd1, 2'd0, 8'h10, 8'h40, 12'd0,    12'd0,    9'd17,
                           11'd640, 10'd0);
        stim[1] = make_row(2'd2, 2'd1, 2'd1, 8'h22, 8'h80, 12'd13,   12'd5,    9'd100,
                           11'd645, 10'd0);
        stim[2] = make_row(2'd1, 2'd0, 2'd0, 8'h05, 8'hc0, 12'd1003, 12'd611,  9'd250,
                           11'd643, 10'd0);
        stim[3] = make_row(2'd0, 2'd3, 2'd2, 8'h60, 8'h20, 12'd37,   12'd3,    9'd479,
                           11'd645, 10'd0);
        // Cut short at column 300 by the start of the next row
        stim[4] = make_row(2'd3, 2'd2, 2'd3, 8'h31, 8'h08, 12'd6,    12'd40,   9'd200,
                           11'd646, 10'd300);
        stim[5] = make_row(2'd2, 2'd2, 2'd3, 8'h44, 8'hf0, 12'd22,   12'd1000, 9'd33,
                           11'd646, 10'd0);

        repeat (3) @(negedge clk);
        rst = 1'b0;

        check_idle(16);
        for (int r = 0; r < NUM_ROWS; r++) begin
            render_line(r);
        end

        $display("Checked %0d pixels: %0d mismatches, %0d other errors",
                 pixels, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/vram_model.sv */
// Video memory model: xorshift-filled word array answering bus reads after a random delay
`timescale 1ns/10ps

module vram_model import layer_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  vram_addr_t bus_addr,
    input  logic       bus_strobe,
    output vram_word_t bus_rddata,
    output logic       bus_ack
);

    localparam int          WORDS = 1 << 15;
    localparam logic [31:0] SEED  = 32'hbe7b2d2a;

    vram_word_t  mem [WORDS];
    logic [31:0] rng;
    logic        busy;
    logic [1:0]  wait_cnt;
    vram_addr_t  req_addr;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Contents follow the generator from address zero upward
    initial begin
        logic [31:0] x;
        x = SEED;
        for (int i = 0; i < WORDS; i++) begin
            x = xorshift(x);
            mem[vram_addr_t'(i)] = x;
        end
    end

    ////////////////////
    // Bus slave
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            bus_ack  <= 1'b0;
            wait_cnt <= 2'd0;
            rng      <= SEED;
        end else begin
            bus_ack <= 1'b0;
            if (busy) begin
                if (wait_cnt == 2'd0) begin
                    busy       <= 1'b0;
                    bus_ack    <= 1'b1;
                    bus_rddata <= mem[req_addr];
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (bus_strobe && !bus_ack) begin
                // 1 to 4 cycles until ack
                busy     <= 1'b1;
                req_addr <= bus_addr;
                wait_cnt <= rng[1:0];
                rng      <= xorshift(rng);
            end
        end
    end

endmodule

/* source/layer_renderer.sv */
// Tile layer line renderer top: address generator, fetch sequencer and pixel serializer
`timescale 1ns/10ps

module layer_renderer import layer_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // Composer
    input  line_idx_t  line_idx,
    input  logic       line_render_start,

    // Layer registers
    input  layer_cfg_t cfg,

    // Video memory bus
    output vram_addr_t bus_addr,
    output logic       bus_strobe,
    input  vram_word_t bus_rddata,
    input  logic       bus_ack,

    // Line buffer
    output lb_idx_t    lb_wridx,
    output color_t     lb_wrdata,
    output logic       lb_wren
);

    ////////////////////
    // Internal links
    ////////////////////

    vram_addr_t   map_addr;
    vram_addr_t   tile_addr;
    logic [1:0]   row_sel;
    logic [7:0]   attr;
    logic         hflip;
    logic         odd_column;
    logic [7:0]   htile_cnt;
    logic         word_cnt;
    vram_word_t   map_word;
    logic         word_valid;
    logic         word_ready;
    render_word_t word;
    logic         word_hflip;
    logic         line_done;

    tile_addr_gen tile_addr_gen_inst (
        .cfg        (cfg),
        .line_idx   (line_idx),
        .htile_cnt  (htile_cnt),
        .word_cnt   (word_cnt),
        .map_word   (map_word),
        .map_addr   (map_addr),
        .tile_addr  (tile_addr),
        .row_sel    (row_sel),
        .attr       (attr),
        .hflip      (hflip),
        .odd_column (odd_column)
    );

    fetch_sequencer fetch_sequencer_inst (
        .clk               (clk),
        .rst               (rst),
        .line_render_start (line_render_start),
        .line_done         (line_done),
        .cfg               (cfg),
        .map_addr          (map_addr),
        .tile_addr         (tile_addr),
        .row_sel           (row_sel),
        .attr              (attr),
        .hflip             (hflip),
        .odd_column        (odd_column),
        .htile_cnt         (htile_cnt),
        .word_cnt          (word_cnt),
        .map_word          (map_word),
        .bus_addr          (bus_addr),
        .bus_strobe        (bus_strobe),
        .bus_rddata        (bus_rddata),
        .bus_ack           (bus_ack),
        .word_valid        (word_valid),
        .word_ready        (word_ready),
        .word              (word),
        .word_hflip        (word_hflip)
    );

    // Fine scroll is the pixel offset inside the first tile
    pixel_serializer pixel_serializer_inst (
        .clk               (clk),
        .rst               (rst),
        .line_render_start (line_render_start),
        .color_depth       (cfg.color_depth),
        .hscroll_fine      (cfg.hscroll[2:0]),
        .word_valid        (word_valid),
        .word_ready        (word_ready),
        .word              (word),
        .word_hflip        (word_hflip),
        .line_done         (line_done),
        .lb_wridx          (lb_wridx),
        .lb_wrdata         (lb_wrdata),
        .lb_wren           (lb_wren)
    );

endmodule

/* source/pixel_serializer.sv */
// Pixel serializer: turns row words into palette indices and writes the line buffer
`timescale 1ns/10ps

module pixel_serializer import layer_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         line_render_start,
    input  logic [1:0]   color_depth,
    input  logic [2:0]   hscroll_fine,

    // From the fetch sequencer
    input  logic         word_valid,
    output logic         word_ready,
    input  render_word_t word,
    input  logic         word_hflip,
    output logic         line_done,

    // Line buffer
    output lb_idx_t      lb_wridx,
    output color_t       lb_wrdata,
    output logic         lb_wren
);

    render_word_t cur_word;
    logic         cur_hflip;
    logic         busy;
    logic [2:0]   px_cnt;
    logic [2:0]   last_px;
    logic [2:0]   pos;
    logic         accept;
    logic         emit;
    lb_idx_t      wr_idx;
    color_t       raw;
    color_t       pix;

    // 8 pixels per narrowed row word, 4 in 8bpp
    assign last_px = (color_depth == 2'd3) ? 3'd3 : 3'd7;

    // Next word lands in the cycle of the last pixel
    assign word_ready = (!busy || (px_cnt == last_px)) && !line_done;
    assign accept     = word_valid && word_ready;
    assign emit       = busy && !line_done;

    ////////////////////
    // Pixel select
    ////////////////////

    assign pos = cur_hflip ? ~px_cnt : px_cnt;

    always_comb begin
        case (color_depth)
            2'd0: begin
                // Foreground in the low nibble, background in the high one
                if (cur_word.row_data[3'd7 - pos]) begin
                    raw = {4'b0000, cur_word.attr[3:0]};
                end else begin
                    raw = {4'b0000, cur_word.attr[7:4]};
                end
            end
            2'd1:    raw = {6'b0, cur_word.row_data[{pos[2], ~pos[1:0], 1'b0} +: 2]};
            2'd2:    raw = {4'b0, cur_word.row_data[{pos[2:1], ~pos[0], 2'b00} +: 4]};
            default: raw = cur_word.row_data[{pos[1:0], 3'b000} +: 8];
        endcase
    end

    // Palette offset on non-zero low colours
    always_comb begin
        pix = raw;
        if (color_depth != 2'd0 && raw[7:4] == 4'h0 && raw[3:0] != 4'h0) begin
            pix[7:4] = cur_word.attr[7:4];
        end
    end

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            px_cnt    <= '0;
            wr_idx    <= '0;
            line_done <= 1'b0;
            lb_wren   <= 1'b0;
        end else if (line_render_start) begin
            busy      <= 1'b0;
            px_cnt    <= '0;
            // Fine scroll starts left of column zero
            wr_idx    <= lb_idx_t'(0) - lb_idx_t'(hscroll_fine);
            line_done <= 1'b0;
            lb_wren   <= 1'b0;
        end else begin
            lb_wren <= emit;

            if (emit) begin
                wr_idx <= wr_idx + lb_idx_t'(1);
                if (wr_idx == lb_idx_t'(LINE_PIXELS - 1)) begin
                    line_done <= 1'b1;
                end
            end

            if (accept) begin
                busy   <= 1'b1;
                px_cnt <= '0;
            end else if (busy) begin
                if (px_cnt == last_px) begin
                    busy <= 1'b0;
                end
                px_cnt <= px_cnt + 3'd1;
            end
        end
    end

    // Word and write data
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_word  <= word;
            cur_hflip <= word_hflip;
        end
        if (emit) begin
            lb_wridx  <= wr_idx;
            lb_wrdata <= pix;
        end
    end

    // Line buffer stays quiet after the last column
    assert property (@(posedge clk) disable iff (rst)
        line_done |=> !lb_wren);

endmodule

/* source/fetch_sequencer.sv */
// Fetch sequencer: bus master for map and tile words, hands tile rows to the pixel stage
`timescale 1ns/10ps

module fetch_sequencer import layer_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         line_render_start,
    input  logic         line_done,
    input  layer_cfg_t   cfg,

    // From the address generator
    input  vram_addr_t   map_addr,
    input  vram_addr_t   tile_addr,
    input  logic [1:0]   row_sel,
    input  logic [7:0]   attr,
    input  logic         hflip,
    input  logic         odd_column,
    output logic [7:0]   htile_cnt,
    output logic         word_cnt,
    output vram_word_t   map_word,

    // Video memory bus
    output vram_addr_t   bus_addr,
    output logic         bus_strobe,
    input  vram_word_t   bus_rddata,
    input  logic         bus_ack,

    // Pixel stage hand-off
    output logic         word_valid,
    input  logic         word_ready,
    output render_word_t word,
    output logic         word_hflip
);

    seq_state_t state;
    logic       strobe_r;
    logic       issue_map;
    logic       issue_tile;
    logic       map_ack;
    logic       tile_ack;
    logic       last_word;
    vram_word_t row_narrow;

    // Strobe drops in the ack cycle
    assign bus_strobe = strobe_r && !bus_ack;

    // A request left over from an aborted line must finish before a new one
    assign issue_map  = (state == FETCH_MAP) && !strobe_r;
    assign issue_tile = (state == FETCH_TILE) && !strobe_r;
    assign map_ack    = (state == WAIT_MAP) && bus_ack;
    assign tile_ack   = (state == WAIT_TILE) && bus_ack;

    // 8bpp rows take two words
    assign last_word = (cfg.color_depth != 2'd3) || word_cnt;

    // Pick the row out of a packed 1bpp or 2bpp word
    always_comb begin
        case (cfg.color_depth)
            2'd0:    row_narrow = {24'b0, bus_rddata[{row_sel, 3'b000} +: 8]};
            2'd1:    row_narrow = {16'b0, bus_rddata[{row_sel[0], 4'b0000} +: 16]};
            default: row_narrow = bus_rddata;
        endcase
    end

    ////////////////////
    // Sequencer FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            strobe_r   <= 1'b0;
            htile_cnt  <= '0;
            word_cnt   <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (bus_ack) begin
                strobe_r <= 1'b0;
            end

            case (state)
                IDLE: begin
                end
                FETCH_MAP: begin
                    if (!strobe_r) begin
                        strobe_r <= 1'b1;
                        state    <= WAIT_MAP;
                    end
                end
                WAIT_MAP: begin
                    if (bus_ack) begin
                        state <= FETCH_TILE;
                    end
                end
                FETCH_TILE: begin
                    if (!strobe_r) begin
                        strobe_r <= 1'b1;
                        state    <= WAIT_TILE;
                    end
                end
                WAIT_TILE: begin
                    if (bus_ack) begin
                        word_valid <= 1'b1;
                        state      <= HANDOFF;
                    end
                end
                HANDOFF: begin
                    if (word_ready) begin
                        word_valid <= 1'b0;
                        if (!last_word) begin
                            word_cnt <= 1'b1;
                            state    <= FETCH_TILE;
                        end else begin
                            word_cnt  <= 1'b0;
                            htile_cnt <= htile_cnt + 8'd1;
                            // New map word after the odd entry of a pair
                            state     <= odd_column ? FETCH_MAP : FETCH_TILE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase

            if (line_done) begin
                state      <= IDLE;
                word_valid <= 1'b0;
            end

            if (line_render_start) begin
                state      <= FETCH_MAP;
                htile_cnt  <= '0;
                word_cnt   <= 1'b0;
                word_valid <= 1'b0;
            end
        end
    end

    // Address and data registers
    always_ff @(posedge clk) begin
        if (issue_map) begin
            bus_addr <= map_addr;
        end else if (issue_tile) begin
            bus_addr <= tile_addr;
        end

        if (map_ack) begin
            map_word <= bus_rddata;
        end

        if (tile_ack) begin
            word.row_data <= row_narrow;
            word.attr     <= attr;
            word_hflip    <= hflip;
        end
    end

    // Ack only answers a request raised at least one cycle earlier
    assert property (@(posedge clk) disable iff (rst)
        bus_ack |-> strobe_r && $past(strobe_r));

endmodule

/* source/tile_addr_gen.sv */
// Tile address generator: scroll, map wrap, entry decode and tile row addressing
`timescale 1ns/10ps

module tile_addr_gen import layer_pkg::*; (
    input  layer_cfg_t  cfg,
    input  line_idx_t   line_idx,
    input  logic [7:0]  htile_cnt,
    input  logic        word_cnt,
    input  vram_word_t  map_word,
    output vram_addr_t  map_addr,
    output vram_addr_t  tile_addr,
    output logic [1:0]  row_sel,
    output logic [7:0]  attr,
    output logic        hflip,
    output logic        odd_column
);

    scroll_t     scrolled_line;
    scroll_t     line_tiles;
    scroll_t     col_tiles;
    logic [7:0]  scrolled_col;
    logic [7:0]  map_row;
    logic [15:0] map_idx;
    logic [15:0] entry;
    tile_idx_t   tile_idx;
    logic        vflip;
    logic [2:0]  tile_row;
    vram_addr_t  tile_offset;

    ////////////////////
    // Map position
    ////////////////////

    assign scrolled_line = scroll_t'(line_idx) + cfg.vscroll;
    assign line_tiles    = scrolled_line >> $clog2(TILE_PX);
    assign col_tiles     = cfg.hscroll >> $clog2(TILE_PX);
    assign scrolled_col  = htile_cnt + col_tiles[7:0];

    // Wrap row to map height, then row * width + column
    always_comb begin
        case (cfg.map_height)
            2'd0:    map_row = {3'b000, line_tiles[4:0]};
            2'd1:    map_row = {2'b00, line_tiles[5:0]};
            2'd2:    map_row = {1'b0, line_tiles[6:0]};
            default: map_row = line_tiles[7:0];
        endcase

        case (cfg.map_width)
            2'd0:    map_idx = {3'b000, map_row, scrolled_col[4:0]};
            2'd1:    map_idx = {2'b00, map_row, scrolled_col[5:0]};
            2'd2:    map_idx = {1'b0, map_row, scrolled_col[6:0]};
            default: map_idx = {map_row, scrolled_col};
        endcase
    end

    // Two entries per map word
    assign map_addr   = (vram_addr_t'(cfg.map_base) << BASE_SHIFT) + map_idx[15:1];
    assign odd_column = map_idx[0];

    ////////////////////
    // Entry decode
    ////////////////////

    assign entry = odd_column ? map_word[31:16] : map_word[15:0];

    // 1bpp entries carry an 8-bit index and a colour byte, no flips
    assign tile_idx = (cfg.color_depth == 2'd0) ? {2'b00, entry[7:0]} : entry[9:0];
    assign hflip    = (cfg.color_depth != 2'd0) && entry[10];
    assign vflip    = (cfg.color_depth != 2'd0) && entry[11];
    assign attr     = (cfg.color_depth == 2'd0) ? entry[15:8] : {entry[15:12], 4'b0000};

    assign tile_row = scrolled_line[2:0] ^ {3{vflip}};
    assign row_sel  = tile_row[1:0];

    // Words per tile: 2, 4, 8, 16 for 1, 2, 4, 8 bpp
    always_comb begin
        case (cfg.color_depth)
            2'd0:    tile_offset = {4'b0000, tile_idx, tile_row[2]};
            2'd1:    tile_offset = {3'b000, tile_idx, tile_row[2:1]};
            2'd2:    tile_offset = {2'b00, tile_idx, tile_row};
            default: tile_offset = {1'b0, tile_idx, tile_row, word_cnt ^ hflip};
        endcase
    end

    assign tile_addr = (vram_addr_t'(cfg.tile_base) << BASE_SHIFT) + tile_offset;

endmodule

/* source/layer_pkg.sv */
// Tile layer renderer shared types, register layout and sequencer states
package layer_pkg;

    ////////////////////
    // Widths
    ////////////////////

    typedef logic [14:0] vram_addr_t;
    typedef logic [31:0] vram_word_t;
    typedef logic [8:0]  line_idx_t;
    typedef logic [11:0] scroll_t;
    typedef logic [9:0]  lb_idx_t;
    typedef logic [7:0]  color_t;
    typedef logic [9:0]  tile_idx_t;

    // Display and tile geometry
    localparam int LINE_PIXELS = 640;
    localparam int TILE_PX     = 8;

    // Base registers count in blocks of 128 words
    localparam int BASE_SHIFT  = 7;

    ////////////////////
    // Layer registers
    ////////////////////

    typedef struct packed {
        logic [1:0] color_depth;    // 0..3 for 1, 2, 4, 8 bpp
        logic [1:0] map_width;      // 0..3 for 32, 64, 128, 256 tiles
        logic [1:0] map_height;
        logic [7:0] map_base;
        logic [7:0] tile_base;
        scroll_t    hscroll;
        scroll_t    vscroll;
    } layer_cfg_t;

    // One tile row word on its way to the pixel stage
    typedef struct packed {
        vram_word_t  row_data;      // pixels packed from bit 0 upward
        logic [7:0]  attr;
    } render_word_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_MAP,
        WAIT_MAP,
        FETCH_TILE,
        WAIT_TILE,
        HANDOFF
    } seq_state_t;

endpackage
